//--- Makefile
# verilator build and run of the usi testbench, from the project root.
TOP := usi_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the trace, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -f tb.f \
		--top-module $(TOP) -Mdir obj_dir -o $(TOP)
	-./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then echo "test failed"; exit 1; fi
	@grep -q "Simulation finished: PASS" sim.log || (echo "test incomplete"; exit 1)

clean:
	rm -rf obj_dir sim.log

//--- source/usi_apb_regs.sv
//**********************************************************
// apb registers with no wait states. prdata is combinational.
// a tx_data write or rx_data read strobes the fifo for one cycle.
//**********************************************************
`include "usi_defines.svh"

module usi_apb_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`USI_ADDR_W-1:0] i_paddr,
  input  logic [`USI_FIFO_W-1:0] i_pwdata,
  input  logic [`USI_CNT_W-1:0]  i_tx_cnt,
  input  logic                   i_tx_full,
  input  logic                   i_tx_empty,
  input  logic [`USI_CNT_W-1:0]  i_rx_cnt,
  input  logic                   i_rx_full,
  input  logic                   i_rx_empty,
  input  logic [`USI_FIFO_W-1:0] i_rx_data,
  input  logic                   i_rx_perr,
  input  logic                   i_rx_ovr,
  input  logic                   i_tx_ovr,
  output logic [`USI_FIFO_W-1:0] o_prdata,
  output logic                   o_tx_push,
  output logic [`USI_FIFO_W-1:0] o_tx_wdata,
  output logic                   o_rx_pop,
  output logic                   o_usi_en,
  output logic                   o_tx_en,
  output logic                   o_rx_en,
  output usi_uart_pkg::parity_e  o_parity,
  output logic [`USI_DIV_W-1:0]  o_div,
  output logic                   o_rx_dma_en,
  output logic                   o_tx_dma_en,
  output logic [`USI_CNT_W-1:0]  o_rx_th,
  output logic [`USI_CNT_W-1:0]  o_tx_th,
  output logic                   o_intr
);

  logic                           wr_acc;
  logic                           rd_acc;
  logic [usi_reg_pkg::CTRL_W-1:0] ctrl_q;
  logic [usi_reg_pkg::INTR_N-1:0] intr_en_q;
  logic [usi_reg_pkg::INTR_N-1:0] intr_sta_q;
  logic [usi_reg_pkg::INTR_N-1:0] intr_set;
  logic [usi_reg_pkg::INTR_N-1:0] intr_clr;

  assign wr_acc = i_psel & i_penable & i_pwrite;
  assign rd_acc = i_psel & i_penable & ~i_pwrite;

  assign o_tx_push  = wr_acc && (i_paddr == usi_reg_pkg::TX_DATA);
  assign o_tx_wdata = i_pwdata;
  assign o_rx_pop   = rd_acc && (i_paddr == usi_reg_pkg::RX_DATA);

  assign o_usi_en = ctrl_q[usi_reg_pkg::CTRL_USI_EN];
  assign o_tx_en  = ctrl_q[usi_reg_pkg::CTRL_TX_EN];
  assign o_rx_en  = ctrl_q[usi_reg_pkg::CTRL_RX_EN];

  always_comb
  begin
    if (!ctrl_q[usi_reg_pkg::CTRL_PAR_EN])
      o_parity = usi_uart_pkg::PAR_NONE;
    else if (ctrl_q[usi_reg_pkg::CTRL_PAR_ODD])
      o_parity = usi_uart_pkg::PAR_ODD;
    else
      o_parity = usi_uart_pkg::PAR_EVEN;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ctrl_q      <= '0;
      o_div       <= `USI_DIV_W'(`USI_DIV_RESET);
      intr_en_q   <= '0;
      o_rx_dma_en <= 1'b0;
      o_tx_dma_en <= 1'b0;
      o_rx_th     <= '0;
      o_tx_th     <= '0;
    end
    else if (wr_acc)
    begin
      case (i_paddr)
        usi_reg_pkg::CTRL:    ctrl_q <= i_pwdata[usi_reg_pkg::CTRL_W-1:0];
        usi_reg_pkg::DIV:     o_div <= i_pwdata[`USI_DIV_W-1:0];
        usi_reg_pkg::INTR_EN: intr_en_q <= i_pwdata[usi_reg_pkg::INTR_N-1:0];
        usi_reg_pkg::DMA_CTRL:
        begin
          o_rx_dma_en <= i_pwdata[usi_reg_pkg::DMA_RX_EN];
          o_tx_dma_en <= i_pwdata[usi_reg_pkg::DMA_TX_EN];
          o_rx_th     <= i_pwdata[usi_reg_pkg::DMA_RX_TH_LSB +: `USI_CNT_W];
          o_tx_th     <= i_pwdata[usi_reg_pkg::DMA_TX_TH_LSB +: `USI_CNT_W];
        end
        default: ;
      endcase
    end
  end

  always_comb
  begin
    intr_set[usi_reg_pkg::INTR_RX_PERR] = i_rx_perr;
    intr_set[usi_reg_pkg::INTR_RX_OVR]  = i_rx_ovr;
    intr_set[usi_reg_pkg::INTR_TX_OVR]  = i_tx_ovr;
  end

  assign intr_clr = (wr_acc && (i_paddr == usi_reg_pkg::INTR_STA)) ?
                    i_pwdata[usi_reg_pkg::INTR_N-1:0] : '0;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      intr_sta_q <= '0;
      o_intr     <= 1'b0;
    end
    else
    begin
      intr_sta_q <= (intr_sta_q & ~intr_clr) | intr_set;  // set wins.
      o_intr     <= |(intr_sta_q & intr_en_q);
    end
  end

  always_comb
  begin
    o_prdata = '0;
    case (i_paddr)
      usi_reg_pkg::CTRL:     o_prdata[usi_reg_pkg::CTRL_W-1:0] = ctrl_q;
      usi_reg_pkg::DIV:      o_prdata[`USI_DIV_W-1:0] = o_div;
      usi_reg_pkg::RX_DATA:  o_prdata = i_rx_data;  // head before the pop.
      usi_reg_pkg::STATUS:
      begin
        o_prdata[usi_reg_pkg::ST_TX_CNT_LSB +: `USI_CNT_W] = i_tx_cnt;
        o_prdata[usi_reg_pkg::ST_RX_CNT_LSB +: `USI_CNT_W] = i_rx_cnt;
        o_prdata[usi_reg_pkg::ST_TX_FULL]  = i_tx_full;
        o_prdata[usi_reg_pkg::ST_TX_EMPTY] = i_tx_empty;
        o_prdata[usi_reg_pkg::ST_RX_FULL]  = i_rx_full;
        o_prdata[usi_reg_pkg::ST_RX_EMPTY] = i_rx_empty;
      end
      usi_reg_pkg::INTR_EN:  o_prdata[usi_reg_pkg::INTR_N-1:0] = intr_en_q;
      usi_reg_pkg::INTR_STA: o_prdata[usi_reg_pkg::INTR_N-1:0] = intr_sta_q;
      usi_reg_pkg::DMA_CTRL:
      begin
        o_prdata[usi_reg_pkg::DMA_RX_EN] = o_rx_dma_en;
        o_prdata[usi_reg_pkg::DMA_TX_EN] = o_tx_dma_en;
        o_prdata[usi_reg_pkg::DMA_RX_TH_LSB +: `USI_CNT_W] = o_rx_th;
        o_prdata[usi_reg_pkg::DMA_TX_TH_LSB +: `USI_CNT_W] = o_tx_th;
      end
      default: o_prdata = '0;
    endcase
  end

endmodule

//--- source/usi_defines.svh
//**********************************************************
// sizes shared by rtl and testbench. fifo depth must be a power of two.
//**********************************************************
`ifndef USI_DEFINES_SVH
`define USI_DEFINES_SVH

`define USI_FIFO_DEPTH 16
`define USI_CNT_W      5
`define USI_FIFO_W     16
`define USI_DATA_W     8
`define USI_ADDR_W     8
`define USI_DIV_W      16
`define USI_DIV_RESET  16

`endif

//--- source/usi_dma_trig.sv
//**********************************************************
// dma request levels and one-cycle event trigger pulses.
//**********************************************************
`include "usi_defines.svh"

module usi_dma_trig (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_usi_en,
  input  logic                  i_rx_dma_en,
  input  logic                  i_tx_dma_en,
  input  logic [`USI_CNT_W-1:0] i_rx_th,
  input  logic [`USI_CNT_W-1:0] i_tx_th,
  input  logic [`USI_CNT_W-1:0] i_rx_cnt,
  input  logic [`USI_CNT_W-1:0] i_tx_cnt,
  input  logic                  i_dma_ack_rx,
  input  logic                  i_dma_ack_tx,
  output logic                  o_dma_req_rx,
  output logic                  o_dma_req_tx,
  output logic                  o_etb_rx_trig,
  output logic                  o_etb_tx_trig
);

  logic rx_cond;
  logic tx_cond;
  logic rx_cond_d;
  logic tx_cond_d;

  assign rx_cond = (i_rx_cnt > i_rx_th) & i_usi_en;
  assign tx_cond = (i_tx_cnt == '0) & i_usi_en;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      o_dma_req_rx  <= 1'b0;
      o_dma_req_tx  <= 1'b0;
      rx_cond_d     <= 1'b0;
      tx_cond_d     <= 1'b0;
      o_etb_rx_trig <= 1'b0;
      o_etb_tx_trig <= 1'b0;
    end
    else
    begin
      if (!i_rx_dma_en || i_dma_ack_rx)
        o_dma_req_rx <= 1'b0;
      else if (i_rx_cnt >= i_rx_th)
        o_dma_req_rx <= 1'b1;
      if (!i_tx_dma_en || i_dma_ack_tx)
        o_dma_req_tx <= 1'b0;
      else if (i_tx_cnt <= i_tx_th)
        o_dma_req_tx <= 1'b1;
      rx_cond_d     <= rx_cond;
      tx_cond_d     <= tx_cond;
      o_etb_rx_trig <= rx_cond & ~rx_cond_d;  // rising edge only.
      o_etb_tx_trig <= tx_cond & ~tx_cond_d;
    end
  end

endmodule

//--- source/usi_reg_pkg.sv
//**********************************************************
// register map. byte addresses, only the low paddr bits decode.
//**********************************************************
`include "usi_defines.svh"

package usi_reg_pkg;

  typedef enum logic [`USI_ADDR_W-1:0] {
    CTRL     = 8'h00,
    DIV      = 8'h04,
    TX_DATA  = 8'h08,  // write pushes.
    RX_DATA  = 8'h0C,  // read pops.
    STATUS   = 8'h10,
    INTR_EN  = 8'h14,
    INTR_STA = 8'h18,  // write one to clear.
    DMA_CTRL = 8'h1C
  } reg_addr_e;

  typedef enum logic [2:0] {
    CTRL_USI_EN  = 3'd0,
    CTRL_TX_EN   = 3'd1,
    CTRL_RX_EN   = 3'd2,
    CTRL_PAR_EN  = 3'd3,
    CTRL_PAR_ODD = 3'd4
  } ctrl_bit_e;

  typedef enum logic [1:0] {
    INTR_RX_PERR = 2'd0,
    INTR_RX_OVR  = 2'd1,
    INTR_TX_OVR  = 2'd2
  } intr_e;

  localparam int CTRL_W = 5;
  localparam int INTR_N = 3;

  // status fields.
  localparam int ST_TX_CNT_LSB = 0;
  localparam int ST_RX_CNT_LSB = 5;
  localparam int ST_TX_FULL    = 10;
  localparam int ST_TX_EMPTY   = 11;
  localparam int ST_RX_FULL    = 12;
  localparam int ST_RX_EMPTY   = 13;

  // dma control fields.
  localparam int DMA_RX_EN     = 0;
  localparam int DMA_TX_EN     = 1;
  localparam int DMA_RX_TH_LSB = 2;
  localparam int DMA_TX_TH_LSB = 7;

endpackage

//--- source/usi_sync_fifo.sv
//**********************************************************
// first-word fall-through fifo. depth must be a power of two.
// push when full is dropped and flagged, pop when empty is ignored.
//**********************************************************
`include "usi_defines.svh"

module usi_sync_fifo #(
  parameter int DEPTH = `USI_FIFO_DEPTH,
  parameter int W     = `USI_FIFO_W
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  i_push,
  input  logic [W-1:0]          i_wdata,
  input  logic                  i_pop,
  output logic [W-1:0]          o_rd_data,
  output logic [`USI_CNT_W-1:0] o_cnt,
  output logic                  o_full,
  output logic                  o_empty,
  output logic                  o_overrun
);

  localparam int PTR_W = $clog2(DEPTH);

  logic [W-1:0]     mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_push;
  logic             do_pop;

  assign o_full    = (o_cnt == `USI_CNT_W'(DEPTH));
  assign o_empty   = (o_cnt == '0);
  assign o_overrun = i_push & o_full;
  assign do_push   = i_push & ~o_full;
  assign do_pop    = i_pop & ~o_empty;
  assign o_rd_data = mem[rd_ptr];

  always_ff @(posedge clk)
  begin
    if (do_push)
      mem[wr_ptr] <= i_wdata;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      o_cnt  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth.
      if (do_pop)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   o_cnt <= o_cnt + 1'b1;
        2'b01:   o_cnt <= o_cnt - 1'b1;
        default: ;
      endcase
    end
  end

endmodule

//--- source/usi_top.sv
//**********************************************************
// serial interface unit. apb port, tx and rx fifos, uart, dma.
//**********************************************************
`include "usi_defines.svh"

module usi_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`USI_ADDR_W-1:0] i_paddr,
  input  logic [`USI_FIFO_W-1:0] i_pwdata,
  input  logic                   i_uart_rxd,
  input  logic                   i_dma_ack_rx,
  input  logic                   i_dma_ack_tx,
  output logic [`USI_FIFO_W-1:0] o_prdata,
  output logic                   o_uart_txd,
  output logic                   o_dma_req_rx,
  output logic                   o_dma_req_tx,
  output logic                   o_etb_rx_trig,
  output logic                   o_etb_tx_trig,
  output logic                   o_intr
);

  logic                   tx_push;
  logic                   tx_pop;
  logic                   rx_push;
  logic                   rx_pop;
  logic [`USI_FIFO_W-1:0] tx_wdata;
  logic [`USI_FIFO_W-1:0] tx_rd_data;
  logic [`USI_FIFO_W-1:0] rx_rd_data;
  logic [`USI_DATA_W-1:0] uart_rx_data;
  logic [`USI_CNT_W-1:0]  tx_cnt;
  logic [`USI_CNT_W-1:0]  rx_cnt;
  logic                   tx_full;
  logic                   tx_empty;
  logic                   rx_full;
  logic                   rx_empty;
  logic                   tx_ovr;
  logic                   rx_ovr;
  logic                   rx_perr;
  logic                   usi_en;
  logic                   tx_en;
  logic                   rx_en;
  usi_uart_pkg::parity_e  parity;
  logic [`USI_DIV_W-1:0]  div;
  logic                   rx_dma_en;
  logic                   tx_dma_en;
  logic [`USI_CNT_W-1:0]  rx_th;
  logic [`USI_CNT_W-1:0]  tx_th;

  usi_apb_regs u_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .i_tx_cnt    (tx_cnt),
    .i_tx_full   (tx_full),
    .i_tx_empty  (tx_empty),
    .i_rx_cnt    (rx_cnt),
    .i_rx_full   (rx_full),
    .i_rx_empty  (rx_empty),
    .i_rx_data   (rx_rd_data),
    .i_rx_perr   (rx_perr),
    .i_rx_ovr    (rx_ovr),
    .i_tx_ovr    (tx_ovr),
    .o_prdata    (o_prdata),
    .o_tx_push   (tx_push),
    .o_tx_wdata  (tx_wdata),
    .o_rx_pop    (rx_pop),
    .o_usi_en    (usi_en),
    .o_tx_en     (tx_en),
    .o_rx_en     (rx_en),
    .o_parity    (parity),
    .o_div       (div),
    .o_rx_dma_en (rx_dma_en),
    .o_tx_dma_en (tx_dma_en),
    .o_rx_th     (rx_th),
    .o_tx_th     (tx_th),
    .o_intr      (o_intr)
  );

  usi_sync_fifo tx_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_push    (tx_push),
    .i_wdata   (tx_wdata),
    .i_pop     (tx_pop),
    .o_rd_data (tx_rd_data),
    .o_cnt     (tx_cnt),
    .o_full    (tx_full),
    .o_empty   (tx_empty),
    .o_overrun (tx_ovr)
  );

  usi_sync_fifo rx_fifo (
    .clk       (clk),
    .rst_n     (rst_n),
    .i_push    (rx_push),
    .i_wdata   ({{(`USI_FIFO_W - `USI_DATA_W){1'b0}}, uart_rx_data}),
    .i_pop     (rx_pop),
    .o_rd_data (rx_rd_data),
    .o_cnt     (rx_cnt),
    .o_full    (rx_full),
    .o_empty   (rx_empty),
    .o_overrun (rx_ovr)
  );

  usi_uart u_uart (
    .clk        (clk),
    .rst_n      (rst_n),
    .i_tx_en    (tx_en),
    .i_rx_en    (rx_en),
    .i_parity   (parity),
    .i_div      (div),
    .i_tx_data  (tx_rd_data[`USI_DATA_W-1:0]),  // low byte of the head word.
    .i_tx_empty (tx_empty),
    .i_rxd      (i_uart_rxd),
    .o_txd      (o_uart_txd),
    .o_tx_pop   (tx_pop),
    .o_rx_push  (rx_push),
    .o_rx_data  (uart_rx_data),
    .o_rx_perr  (rx_perr)
  );

  usi_dma_trig u_dma_trig (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_usi_en      (usi_en),
    .i_rx_dma_en   (rx_dma_en),
    .i_tx_dma_en   (tx_dma_en),
    .i_rx_th       (rx_th),
    .i_tx_th       (tx_th),
    .i_rx_cnt      (rx_cnt),
    .i_tx_cnt      (tx_cnt),
    .i_dma_ack_rx  (i_dma_ack_rx),
    .i_dma_ack_tx  (i_dma_ack_tx),
    .o_dma_req_rx  (o_dma_req_rx),
    .o_dma_req_tx  (o_dma_req_tx),
    .o_etb_rx_trig (o_etb_rx_trig),
    .o_etb_tx_trig (o_etb_tx_trig)
  );

endmodule

//--- source/usi_uart.sv
//**********************************************************
// 8n1 uart with optional parity. i_div is clocks per bit, at least 2.
// stop bit is not checked, the byte is pushed at its middle.
//**********************************************************
`include "usi_defines.svh"

module usi_uart (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   i_tx_en,
  input  logic                   i_rx_en,
  input  usi_uart_pkg::parity_e  i_parity,
  input  logic [`USI_DIV_W-1:0]  i_div,
  input  logic [`USI_DATA_W-1:0] i_tx_data,
  input  logic                   i_tx_empty,
  input  logic                   i_rxd,
  output logic                   o_txd,
  output logic                   o_tx_pop,
  output logic                   o_rx_push,
  output logic [`USI_DATA_W-1:0] o_rx_data,
  output logic                   o_rx_perr
);

  localparam int IDX_W = $clog2(`USI_DATA_W);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(`USI_DATA_W - 1);

  usi_uart_pkg::uart_state_e tx_state;
  usi_uart_pkg::uart_state_e rx_state;
  logic [`USI_DIV_W-1:0]     tx_tmr;
  logic [`USI_DIV_W-1:0]     rx_tmr;
  logic [IDX_W-1:0]          tx_idx;
  logic [IDX_W-1:0]          rx_idx;
  logic [`USI_DATA_W-1:0]    tx_shift;
  logic [`USI_DATA_W-1:0]    rx_shift;
  logic                      tx_par;
  logic                      tx_tick;
  logic                      rx_tick;
  logic                      rx_half;
  logic                      rx_step;
  logic                      rxd_s1;
  logic                      rxd_s2;
  logic                      rx_par_bad;
  logic                      par_en;
  logic                      par_odd;

  assign par_en   = (i_parity != usi_uart_pkg::PAR_NONE);
  assign par_odd  = (i_parity == usi_uart_pkg::PAR_ODD);
  assign tx_tick  = (tx_tmr == i_div - 1'b1);
  assign rx_tick  = (rx_tmr == i_div - 1'b1);
  assign rx_half  = (rx_tmr == (i_div >> 1) - 1'b1);
  assign rx_step  = (rx_state == usi_uart_pkg::START) ? rx_half : rx_tick;
  assign o_tx_pop = (tx_state == usi_uart_pkg::IDLE) & i_tx_en & ~i_tx_empty;

  always_ff @(posedge clk)
  begin
    if (o_tx_pop)
    begin
      tx_shift <= i_tx_data;
      tx_par   <= ^i_tx_data ^ par_odd;
    end
    else if (tx_tick && (tx_state == usi_uart_pkg::START || tx_state == usi_uart_pkg::DATA))
      tx_shift <= tx_shift >> 1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      tx_state <= usi_uart_pkg::IDLE;
      tx_tmr   <= '0;
      tx_idx   <= '0;
      o_txd    <= 1'b1;  // line idles high.
    end
    else
    begin
      tx_tmr <= (tx_state == usi_uart_pkg::IDLE || tx_tick) ? '0 : tx_tmr + 1'b1;
      case (tx_state)
        usi_uart_pkg::IDLE:
          if (o_tx_pop)
          begin
            tx_state <= usi_uart_pkg::START;
            o_txd    <= 1'b0;
          end
        usi_uart_pkg::START:
          if (tx_tick)
          begin
            tx_state <= usi_uart_pkg::DATA;
            tx_idx   <= '0;
            o_txd    <= tx_shift[0];  // lsb first.
          end
        usi_uart_pkg::DATA:
          if (tx_tick)
          begin
            if (tx_idx == LAST_IDX)
            begin
              tx_state <= par_en ? usi_uart_pkg::PARITY : usi_uart_pkg::STOP;
              o_txd    <= par_en ? tx_par : 1'b1;
            end
            else
            begin
              tx_idx <= tx_idx + 1'b1;
              o_txd  <= tx_shift[0];
            end
          end
        usi_uart_pkg::PARITY:
          if (tx_tick)
          begin
            tx_state <= usi_uart_pkg::STOP;
            o_txd    <= 1'b1;
          end
        usi_uart_pkg::STOP:
          if (tx_tick)
            tx_state <= usi_uart_pkg::IDLE;
        default: tx_state <= usi_uart_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (rx_step && rx_state == usi_uart_pkg::DATA)
      rx_shift <= {rxd_s2, rx_shift[`USI_DATA_W-1:1]};
    if (rx_step && rx_state == usi_uart_pkg::STOP)
      o_rx_data <= rx_shift;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rxd_s1     <= 1'b1;
      rxd_s2     <= 1'b1;
      rx_state   <= usi_uart_pkg::IDLE;
      rx_tmr     <= '0;
      rx_idx     <= '0;
      rx_par_bad <= 1'b0;
      o_rx_push  <= 1'b0;
      o_rx_perr  <= 1'b0;
    end
    else
    begin
      rxd_s1    <= i_rxd;
      rxd_s2    <= rxd_s1;
      o_rx_push <= 1'b0;
      o_rx_perr <= 1'b0;
      rx_tmr    <= (rx_state == usi_uart_pkg::IDLE || rx_step) ? '0 : rx_tmr + 1'b1;
      case (rx_state)
        usi_uart_pkg::IDLE:
        begin
          rx_par_bad <= 1'b0;
          if (i_rx_en && !rxd_s2)
            rx_state <= usi_uart_pkg::START;
        end
        usi_uart_pkg::START:
          if (rx_step)
          begin
            rx_idx   <= '0;
            rx_state <= rxd_s2 ? usi_uart_pkg::IDLE : usi_uart_pkg::DATA;  // glitch rejected.
          end
        usi_uart_pkg::DATA:
          if (rx_step)
          begin
            if (rx_idx == LAST_IDX)
              rx_state <= par_en ? usi_uart_pkg::PARITY : usi_uart_pkg::STOP;
            else
              rx_idx <= rx_idx + 1'b1;
          end
        usi_uart_pkg::PARITY:
          if (rx_step)
          begin
            rx_par_bad <= (rxd_s2 != (^rx_shift ^ par_odd));
            rx_state   <= usi_uart_pkg::STOP;
          end
        usi_uart_pkg::STOP:
          if (rx_step)
          begin
            o_rx_push <= 1'b1;
            o_rx_perr <= rx_par_bad;
            rx_state  <= usi_uart_pkg::IDLE;
          end
        default: rx_state <= usi_uart_pkg::IDLE;
      endcase
    end
  end

endmodule

//--- source/usi_uart_pkg.sv
//**********************************************************
// uart frame states and parity modes.
//**********************************************************
package usi_uart_pkg;

  typedef enum logic [2:0] {
    IDLE,
    START,
    DATA,
    PARITY,
    STOP
  } uart_state_e;

  typedef enum logic [1:0] {
    PAR_NONE,
    PAR_EVEN,
    PAR_ODD
  } parity_e;

endpackage

//--- tb.f
+incdir+source
source/usi_reg_pkg.sv
source/usi_uart_pkg.sv
source/usi_apb_regs.sv
source/usi_sync_fifo.sv
source/usi_uart.sv
source/usi_dma_trig.sv
source/usi_top.sv
testbench/usi_tb.sv

//--- testbench/usi_tb.sv
//**********************************************************
// plays testbench/usi_trace.txt, run from the project root.
// stops at the first mismatch or timeout.
//**********************************************************
`include "usi_defines.svh"

module usi_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_CYCLES = 4000;

  typedef enum logic [2:0] {
    OP_W,
    OP_R,
    OP_T,
    OP_S,
    OP_I,
    OP_D,
    OP_G,
    OP_BAD
  } trace_op_e;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`USI_ADDR_W-1:0] paddr;
  logic [`USI_FIFO_W-1:0] pwdata;
  logic                   uart_rxd;
  logic                   dma_ack_rx;
  logic                   dma_ack_tx;
  logic [`USI_FIFO_W-1:0] prdata;
  logic                   uart_txd;
  logic                   dma_req_rx;
  logic                   dma_req_tx;
  logic                   etb_rx_trig;
  logic                   etb_tx_trig;
  logic                   intr;

  logic [usi_reg_pkg::CTRL_W-1:0] ctrl_shadow;
  logic                           tx_dma_shadow;
  logic                           tx_dma_prev;
  int                             div_shadow;
  int                             errors = 0;
  int                             rx_trig_cnt = 0;
  int                             tx_trig_cnt = 0;
  int                             rx_trig_seen;
  int                             tx_trig_seen;

  always #2 clk = ~clk;  // 4 ns period.

  usi_top usi_top_inst (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_psel        (psel),
    .i_penable     (penable),
    .i_pwrite      (pwrite),
    .i_paddr       (paddr),
    .i_pwdata      (pwdata),
    .i_uart_rxd    (uart_rxd),
    .i_dma_ack_rx  (dma_ack_rx),
    .i_dma_ack_tx  (dma_ack_tx),
    .o_prdata      (prdata),
    .o_uart_txd    (uart_txd),
    .o_dma_req_rx  (dma_req_rx),
    .o_dma_req_tx  (dma_req_tx),
    .o_etb_rx_trig (etb_rx_trig),
    .o_etb_tx_trig (etb_tx_trig),
    .o_intr        (intr)
  );

  // trigger pulses, counted mid-cycle.
  always @(negedge clk)
  begin
    if (etb_rx_trig)
      rx_trig_cnt = rx_trig_cnt + 1;
    if (etb_tx_trig)
      tx_trig_cnt = tx_trig_cnt + 1;
  end

  // tx dma request stays low while tx_dma_en is off.
  always @(negedge clk)
  begin
    if (rst_n === 1'b1 && !tx_dma_shadow && !tx_dma_prev)
      check_value("dma_req_tx disabled", 16'h0000, {15'h0, dma_req_tx});
    tx_dma_prev = tx_dma_shadow;
  end

  task automatic fail_run(input string msg);
    errors = errors + 1;
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [15:0] exp,
                             input logic [15:0] act);
    assert (act === exp)
    else
      fail_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  // odd parity sets the bit when the ones count is even.
  function automatic logic parity_bit(input logic [7:0] d, input logic odd);
    int ones;
    int i;
    ones = 0;
    for (i = 0; i < 8; i++)
    begin
      if (d[i])
        ones = ones + 1;
    end
    return (ones % 2 == 1) ? !odd : odd;
  endfunction

  function automatic trace_op_e decode_op(input logic [7:0] c);
    case (c)
      "W":     return OP_W;
      "R":     return OP_R;
      "T":     return OP_T;
      "S":     return OP_S;
      "I":     return OP_I;
      "D":     return OP_D;
      "G":     return OP_G;
      default: return OP_BAD;
    endcase
  endfunction

  function automatic logic req_level(input logic sel);
    return sel ? dma_req_tx : dma_req_rx;
  endfunction

  function automatic int pulses_since(input logic sel);
    return sel ? tx_trig_cnt - tx_trig_seen : rx_trig_cnt - rx_trig_seen;
  endfunction

  task automatic apb_write(input logic [7:0] addr, input logic [15:0] data);
    tick();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    tick();
    penable = 1'b1;
    tick();  // access done on this edge.
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [15:0] data);
    tick();
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    tick();
    penable = 1'b1;
    @(negedge clk);
    data = prdata;  // head before the pop.
    tick();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic expect_tx_byte(input logic [7:0] exp, input string name);
    int         n;
    int         i;
    logic [7:0] got;
    n = 0;
    @(negedge clk);
    while (uart_txd !== 1'b0 && n < WAIT_CYCLES)
    begin
      @(negedge clk);
      n = n + 1;
    end
    assert (uart_txd === 1'b0)
    else
      fail_run($sformatf("timeout: no start bit on o_uart_txd for %s", name));
    repeat (div_shadow / 2) @(negedge clk);  // middle of start bit.
    check_value({name, " start"}, 16'h0000, {15'h0, uart_txd});
    for (i = 0; i < `USI_DATA_W; i++)
    begin
      repeat (div_shadow) @(negedge clk);
      got[i] = uart_txd;
    end
    check_value(name, {8'h00, exp}, {8'h00, got});
    if (ctrl_shadow[usi_reg_pkg::CTRL_PAR_EN])
    begin
      repeat (div_shadow) @(negedge clk);
      check_value({name, " parity"},
                  {15'h0, parity_bit(exp, ctrl_shadow[usi_reg_pkg::CTRL_PAR_ODD])},
                  {15'h0, uart_txd});
    end
    repeat (div_shadow) @(negedge clk);
    check_value({name, " stop"}, 16'h0001, {15'h0, uart_txd});
  endtask

  task automatic drive_bit(input logic b);
    uart_rxd = b;
    repeat (div_shadow) tick();
  endtask

  task automatic send_rx_byte(input logic [7:0] data, input logic bad_par);
    int   i;
    logic par;
    par = parity_bit(data, ctrl_shadow[usi_reg_pkg::CTRL_PAR_ODD]) ^ bad_par;
    drive_bit(1'b0);
    for (i = 0; i < `USI_DATA_W; i++)
      drive_bit(data[i]);  // lsb first.
    if (ctrl_shadow[usi_reg_pkg::CTRL_PAR_EN])
      drive_bit(par);
    drive_bit(1'b1);
    drive_bit(1'b1);  // idle gap.
  endtask

  task automatic expect_intr(input logic lvl, input string name);
    int n;
    n = 0;
    while (intr !== lvl && n < WAIT_CYCLES)
    begin
      tick();
      n = n + 1;
    end
    assert (intr === lvl)
    else
      fail_run($sformatf("timeout: o_intr did not go to %0d for %s", lvl, name));
  endtask

  task automatic expect_dma_req(input logic sel, input logic lvl, input string name);
    int n;
    n = 0;
    while (req_level(sel) !== lvl && n < WAIT_CYCLES)
    begin
      tick();
      n = n + 1;
    end
    assert (req_level(sel) === lvl)
    else
      fail_run($sformatf("timeout: dma request %0d did not go to %0d for %s",
                         sel, lvl, name));
    if (sel)
      dma_ack_tx = 1'b1;
    else
      dma_ack_rx = 1'b1;
    tick();
    dma_ack_rx = 1'b0;
    dma_ack_tx = 1'b0;
    check_value({name, " after ack"}, 16'h0000, {15'h0, req_level(sel)});
    if (!lvl)
    begin
      repeat (8)
      begin
        tick();
        check_value({name, " held low"}, 16'h0000, {15'h0, req_level(sel)});
      end
    end
  endtask

  task automatic expect_trig(input logic sel, input int exp, input string name);
    int n;
    n = 0;
    while (pulses_since(sel) < exp && n < WAIT_CYCLES)
    begin
      tick();
      n = n + 1;
    end
    assert (pulses_since(sel) >= exp)
    else
      fail_run($sformatf("timeout: trigger %0d did not pulse for %s", sel, name));
    check_value(name, 16'(exp), 16'(pulses_since(sel)));
    if (sel)
      tx_trig_seen = tx_trig_cnt;
    else
      rx_trig_seen = rx_trig_cnt;
  endtask

  task automatic play_trace();
    int               fd;
    int               nf;
    int               k;
    int               cnt;
    logic [8*128-1:0] line_v;
    logic [8*32-1:0]  name_v;
    logic [7:0]       op_c;
    logic [15:0]      a;
    logic [15:0]      b;
    logic [15:0]      got;
    string            name;
    fd = $fopen("testbench/usi_trace.txt", "r");
    if (fd == 0)
      fail_run("could not open testbench/usi_trace.txt");
    while (!$feof(fd))
    begin
      line_v = '0;
      nf = $fgets(line_v, fd);
      if (nf > 0)
        nf = $sscanf(line_v, "%s %h %h %d %s", op_c, a, b, cnt, name_v);
      if (nf > 0 && op_c != "#")
      begin
        if (nf != 5)
          fail_run($sformatf("malformed trace line: %0s", line_v));
        name = $sformatf("%0s", name_v);
        case (decode_op(op_c))
          OP_W:
          begin
            for (k = 0; k < cnt; k++)
              apb_write(a[7:0], b + 16'(k));  // data steps per repeat.
            if (a[7:0] == usi_reg_pkg::CTRL)
              ctrl_shadow = b[usi_reg_pkg::CTRL_W-1:0];
            if (a[7:0] == usi_reg_pkg::DIV)
              div_shadow = int'(b);
            if (a[7:0] == usi_reg_pkg::DMA_CTRL)
              tx_dma_shadow = b[usi_reg_pkg::DMA_TX_EN];
          end
          OP_R:
          begin
            apb_read(a[7:0], got);
            check_value(name, b, got);
          end
          OP_T:    expect_tx_byte(a[7:0], name);
          OP_S:    send_rx_byte(a[7:0], b[0]);
          OP_I:    expect_intr(a[0], name);
          OP_D:    expect_dma_req(a[0], b[0], name);
          OP_G:    expect_trig(a[0], int'(b), name);
          default: fail_run($sformatf("unknown trace opcode in line: %0s", line_v));
        endcase
      end
    end
    $fclose(fd);
  endtask

  initial
  begin
    rst_n         = 1'b0;
    psel          = 1'b0;
    penable       = 1'b0;
    pwrite        = 1'b0;
    paddr         = '0;
    pwdata        = '0;
    uart_rxd      = 1'b1;
    dma_ack_rx    = 1'b0;
    dma_ack_tx    = 1'b0;
    ctrl_shadow   = '0;
    tx_dma_shadow = 1'b0;
    tx_dma_prev   = 1'b0;
    div_shadow    = `USI_DIV_RESET;
    rx_trig_seen  = 0;
    tx_trig_seen  = 0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    play_trace();
    if (errors == 0)
    begin
      $display("Simulation finished: PASS");
      $finish;
    end
    else
      fail_run("trace ended with errors");
  end

endmodule

//--- testbench/usi_trace.txt
# op a b n name. W addr data repeat, R addr expect, T byte, S byte badpar,
# I level, D sel(0 rx 1 tx) level, G sel pulses-since-last. a, b in hex.
W 04 0008 1 div_set
W 08 0041 1 tx_wr0
W 08 00a5 1 tx_wr1
W 08 003c 1 tx_wr2
W 00 0003 1 tx_enable
T 41 0 0 tx_byte0
T a5 0 0 tx_byte1
T 3c 0 0 tx_byte2
R 10 2800 0 tx_status
G 1 1 0 tx_trig
W 00 000f 1 rx_even_cfg
S 5a 0 0 rx_send0
S c3 0 0 rx_send1
R 10 0840 0 rx_status2
R 0c 005a 0 rx_data0
R 0c 00c3 0 rx_data1
R 10 2800 0 rx_status0
W 14 0001 1 perr_intr_en
S 96 1 0 perr_send
I 1 0 0 perr_intr_high
R 18 0001 0 perr_sta
W 18 0001 1 perr_clear
I 0 0 0 perr_intr_low
R 0c 0096 0 perr_data
G 0 2 0 rx_trig_early
W 00 0001 1 ovr_cfg
W 08 0100 17 ovr_fill
R 10 2410 0 ovr_status
R 18 0004 0 ovr_sta
W 00 0005 1 dma_cfg
W 1c 0009 1 dma_en
S 11 0 0 dma_send0
S 22 0 0 dma_send1
S 33 0 0 dma_send2
D 0 1 0 dma_req_high
D 0 1 0 dma_req_again
W 1c 0008 1 dma_off
D 0 0 0 dma_req_off
G 0 1 0 rx_trig_th
